// ==== dma_pkg.sv ====
`default_nettype none

package dma_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] count_t;
	typedef logic [1:0] reg_addr_t;

	// Kinds 0 and 3 are rejected by the engine
	typedef enum logic [1:0] {
		CMD_FILL = 2'd1,
		CMD_COPY = 2'd2
	} cmd_kind_e;

	// 98 bits, kind in the top two
	typedef struct packed {
		cmd_kind_e kind;
		word_t value_or_src; // Fill value or copy source
		addr_t dst;
		count_t count;
	} dma_cmd_t;

	typedef struct packed {
		logic done;  // One cycle per command
		logic error; // Invalid kind
	} dma_done_t;

	typedef struct packed {
		logic busy;
		logic [7:0] err_count;
		logic [15:0] done_count;
		logic queue_empty;
	} dma_status_t;

	// CPU register map
	localparam reg_addr_t REG_VALUE = 2'd0;
	localparam reg_addr_t REG_DST = 2'd1;
	localparam reg_addr_t REG_COUNT = 2'd2;
	localparam reg_addr_t REG_KIND = 2'd3; // Write pushes, read gives status

endpackage

`default_nettype wire

// ==== dma_reg_decode.sv ====
`default_nettype none

module dma_reg_decode (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_req,
	input wire logic i_rw,
	input wire dma_pkg::reg_addr_t i_addr,
	input wire dma_pkg::word_t i_wdata,
	input wire dma_pkg::dma_status_t i_status,
	input wire logic i_push_ready,
	output dma_pkg::word_t o_rdata,
	output logic o_ready,
	output logic o_push_valid,
	output dma_pkg::dma_cmd_t o_push_data
);
	dma_pkg::word_t value_q;
	dma_pkg::addr_t dst_q;
	dma_pkg::count_t count_q;
	dma_pkg::word_t status_word;
	dma_pkg::word_t read_word;
	logic accept;
	logic kind_write;

	assign accept = i_req && !o_ready; // Request not yet answered
	assign kind_write = i_rw && (i_addr == dma_pkg::REG_KIND);

	// Command offered straight from the CPU write, held by the CPU until ready
	assign o_push_valid = accept && kind_write;
	assign o_push_data = '{
		kind: dma_pkg::cmd_kind_e'(i_wdata[1:0]),
		value_or_src: value_q,
		dst: dst_q,
		count: count_q
	};

	assign status_word = {i_status.done_count, i_status.err_count, 7'd0, i_status.busy};

	always_comb begin
		case (i_addr)
			dma_pkg::REG_VALUE: read_word = value_q;
			dma_pkg::REG_DST: read_word = dst_q;
			dma_pkg::REG_COUNT: read_word = count_q;
			default: read_word = status_word;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
		end else if (!i_req) begin
			o_ready <= 1'b0;
		end else if (accept) begin
			o_ready <= kind_write ? i_push_ready : 1'b1; // Full queue stalls the CPU
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			if (!i_rw) begin
				o_rdata <= read_word;
			end else begin
				case (i_addr)
					dma_pkg::REG_VALUE: value_q <= i_wdata;
					dma_pkg::REG_DST: dst_q <= i_wdata;
					dma_pkg::REG_COUNT: count_q <= i_wdata;
					default: ; // Kind goes out with the push
				endcase
			end
		end
	end

	// Relies on the CPU holding its request until ready
	a_push_stable: assert property (@(posedge i_clock) disable iff (i_rst)
		(o_push_valid && !i_push_ready) |=> (o_push_valid && $stable(o_push_data)));

endmodule

`default_nettype wire

// ==== dma_cmd_queue.sv ====
`default_nettype none

module dma_cmd_queue #(
	parameter int DEPTH = 8
) (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_push_valid,
	input wire dma_pkg::dma_cmd_t i_push_data,
	input wire logic i_pop_ready,
	output logic o_push_ready,
	output logic o_pop_valid,
	output dma_pkg::dma_cmd_t o_pop_data,
	output logic o_empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	dma_pkg::dma_cmd_t mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	logic push_fire;
	logic pop_fire;

	// Wraps for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign o_empty = (count == '0);
	assign o_push_ready = !full;
	assign o_pop_valid = !o_empty; // Registered storage, no fall-through
	assign o_pop_data = mem[rd_ptr];
	assign push_fire = i_push_valid && o_push_ready;
	assign pop_fire = o_pop_valid && i_pop_ready;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push_fire) wr_ptr <= next_ptr(wr_ptr);
			if (pop_fire) rd_ptr <= next_ptr(rd_ptr);
			case ({push_fire, pop_fire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (push_fire) mem[wr_ptr] <= i_push_data;
	end

	a_no_push_full: assert property (@(posedge i_clock) disable iff (i_rst)
		(full && !pop_fire) |=> (full && wr_ptr == rd_ptr));
	a_no_pop_empty: assert property (@(posedge i_clock) disable iff (i_rst)
		(o_empty && !push_fire) |=> (o_empty && rd_ptr == wr_ptr));

endmodule

`default_nettype wire

// ==== dma_engine.sv ====
`default_nettype none

module dma_engine (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_stall,
	input wire logic i_pop_valid,
	input wire dma_pkg::dma_cmd_t i_pop_data,
	input wire logic i_bus_ready,
	input wire dma_pkg::word_t i_bus_rdata,
	output logic o_pop_ready,
	output logic o_active,
	output dma_pkg::dma_done_t o_done,
	output logic o_bus_req,
	output logic o_bus_rw,
	output dma_pkg::addr_t o_bus_addr,
	output dma_pkg::word_t o_bus_wdata
);
	typedef enum logic [3:0] {
		IDLE,
		LOAD,
		FILL_REQ,
		FILL_WAIT,
		COPY_RD_REQ,
		COPY_RD_WAIT,
		COPY_WR_REQ,
		COPY_WR_WAIT,
		FINISH
	} state_e;

	state_e state;
	dma_pkg::dma_cmd_t work;   // Working copy, addresses and count advance
	dma_pkg::word_t copy_data; // One word between read and write
	logic bad_kind;

	assign o_pop_ready = (state == IDLE);
	assign o_active = (state != IDLE);
	assign o_done = '{done: (state == FINISH), error: (state == FINISH) && bad_kind};

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= IDLE;
			o_bus_req <= 1'b0;
			o_bus_rw <= 1'b0;
			bad_kind <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (i_pop_valid) begin
						work <= i_pop_data;
						state <= LOAD;
					end
				end
				LOAD: begin
					bad_kind <= 1'b0;
					case (work.kind)
						dma_pkg::CMD_FILL: state <= (work.count == '0) ? FINISH : FILL_REQ;
						dma_pkg::CMD_COPY: state <= (work.count == '0) ? FINISH : COPY_RD_REQ;
						default: begin
							bad_kind <= 1'b1;
							state <= FINISH;
						end
					endcase
				end
				FILL_REQ: begin
					if (!i_stall) begin
						o_bus_req <= 1'b1;
						o_bus_rw <= 1'b1;
						o_bus_addr <= work.dst;
						o_bus_wdata <= work.value_or_src;
						state <= FILL_WAIT;
					end
				end
				FILL_WAIT: begin
					if (i_bus_ready) begin
						o_bus_req <= 1'b0;
						work.dst <= work.dst + 32'd4;
						work.count <= work.count - 1'b1;
						state <= (work.count == 32'd1) ? FINISH : FILL_REQ;
					end
				end
				COPY_RD_REQ: begin
					if (!i_stall) begin
						o_bus_req <= 1'b1;
						o_bus_rw <= 1'b0;
						o_bus_addr <= work.value_or_src;
						state <= COPY_RD_WAIT;
					end
				end
				COPY_RD_WAIT: begin
					if (i_bus_ready) begin
						o_bus_req <= 1'b0;
						copy_data <= i_bus_rdata; // Sampled on the ready cycle
						work.value_or_src <= work.value_or_src + 32'd4;
						state <= COPY_WR_REQ;
					end
				end
				COPY_WR_REQ: begin
					if (!i_stall) begin
						o_bus_req <= 1'b1;
						o_bus_rw <= 1'b1;
						o_bus_addr <= work.dst;
						o_bus_wdata <= copy_data;
						state <= COPY_WR_WAIT;
					end
				end
				COPY_WR_WAIT: begin
					if (i_bus_ready) begin
						o_bus_req <= 1'b0;
						work.dst <= work.dst + 32'd4;
						work.count <= work.count - 1'b1;
						state <= (work.count == 32'd1) ? FINISH : COPY_RD_REQ;
					end
				end
				FINISH: state <= IDLE; // Done pulse this cycle
				default: state <= IDLE;
			endcase
		end
	end

	// Bus slave may take any number of cycles
	a_bus_hold: assert property (@(posedge i_clock) disable iff (i_rst)
		(o_bus_req && !i_bus_ready) |=> (o_bus_req && $stable(o_bus_addr)
		&& $stable(o_bus_rw) && $stable(o_bus_wdata)));

endmodule

`default_nettype wire

// ==== dma_status.sv ====
`default_nettype none

module dma_status (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire dma_pkg::dma_done_t i_done,
	input wire logic i_queue_empty,
	input wire logic i_engine_active,
	input wire logic i_push_pending,
	output dma_pkg::dma_status_t o_status
);
	logic busy_next;

	// Pending push covers the cycle before the queue sees it
	assign busy_next = !i_queue_empty || i_engine_active || i_push_pending;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			o_status <= '0;
		end else begin
			o_status.busy <= busy_next;
			o_status.queue_empty <= i_queue_empty;
			if (i_done.done) begin
				if (i_done.error) begin
					if (o_status.err_count != '1)
						o_status.err_count <= o_status.err_count + 1'b1;
				end else if (o_status.done_count != '1) begin
					o_status.done_count <= o_status.done_count + 1'b1; // Saturates
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== dma_top.sv ====
`default_nettype none

module dma_top #(
	parameter int QUEUE_DEPTH = 8
) (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_req,
	input wire logic i_rw,
	input wire dma_pkg::reg_addr_t i_addr,
	input wire dma_pkg::word_t i_wdata,
	output dma_pkg::word_t o_rdata,
	output logic o_ready,
	input wire logic i_stall,
	output logic o_bus_req,
	output logic o_bus_rw,
	output dma_pkg::addr_t o_bus_addr,
	output dma_pkg::word_t o_bus_wdata,
	input wire logic i_bus_ready,
	input wire dma_pkg::word_t i_bus_rdata
);
	logic push_valid;
	logic push_ready;
	dma_pkg::dma_cmd_t push_data;
	logic pop_valid;
	logic pop_ready;
	dma_pkg::dma_cmd_t pop_data;
	logic queue_empty;
	logic engine_active;
	dma_pkg::dma_done_t done;
	dma_pkg::dma_status_t status;

	dma_reg_decode u_decode (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_req(i_req), .i_rw(i_rw), .i_addr(i_addr), .i_wdata(i_wdata),
		.i_status(status), .i_push_ready(push_ready),
		.o_rdata(o_rdata), .o_ready(o_ready),
		.o_push_valid(push_valid), .o_push_data(push_data)
	);

	dma_cmd_queue #(.DEPTH(QUEUE_DEPTH)) u_queue (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_push_valid(push_valid), .i_push_data(push_data), .i_pop_ready(pop_ready),
		.o_push_ready(push_ready), .o_pop_valid(pop_valid), .o_pop_data(pop_data),
		.o_empty(queue_empty)
	);

	dma_engine u_engine (
		.i_clock(i_clock), .i_rst(i_rst), .i_stall(i_stall),
		.i_pop_valid(pop_valid), .i_pop_data(pop_data),
		.i_bus_ready(i_bus_ready), .i_bus_rdata(i_bus_rdata),
		.o_pop_ready(pop_ready), .o_active(engine_active), .o_done(done),
		.o_bus_req(o_bus_req), .o_bus_rw(o_bus_rw),
		.o_bus_addr(o_bus_addr), .o_bus_wdata(o_bus_wdata)
	);

	dma_status u_status (
		.i_clock(i_clock), .i_rst(i_rst), .i_done(done),
		.i_queue_empty(queue_empty), .i_engine_active(engine_active),
		.i_push_pending(push_valid), .o_status(status)
	);

endmodule

`default_nettype wire

// ==== tb_dma_checker.sv ====
`default_nettype none

module tb_dma_checker (
	input wire logic i_clock,
	input wire logic i_rst,
	input wire logic i_req,
	input wire logic i_rw,
	input wire dma_pkg::reg_addr_t i_addr,
	input wire dma_pkg::word_t i_wdata,
	input wire dma_pkg::word_t i_rdata,
	input wire logic i_cpu_ready,
	input wire logic i_stall,
	input wire logic i_bus_req,
	input wire logic i_bus_rw,
	input wire dma_pkg::addr_t i_bus_addr,
	input wire dma_pkg::word_t i_bus_wdata,
	input wire logic i_bus_ready,
	output int o_mismatches,
	output int o_other_errors,
	output int o_pending,
	output int o_cpu_stalls
);
	timeunit 1ns;
	timeprecision 100ps;

	dma_pkg::dma_cmd_t exp_q[$]; // Commands that still owe bus writes
	dma_pkg::word_t sh_value;
	dma_pkg::addr_t sh_dst;
	dma_pkg::count_t sh_count;
	int word_idx = 0;
	int valid_cnt = 0;
	int invalid_cnt = 0;
	int mismatches = 0;
	int other_errors = 0;
	int wait_cycles = 0;
	int cpu_stalls = 0;
	logic ready_q;
	logic req_q;
	logic stall_q;

	assign o_mismatches = mismatches;
	assign o_other_errors = other_errors;
	assign o_pending = exp_q.size();
	assign o_cpu_stalls = cpu_stalls;

	function automatic dma_pkg::word_t mem_init(input dma_pkg::addr_t a);
		return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
	endfunction

	// Address and data of write n of a command, regions never overlap
	function automatic logic [63:0] expected_write(input dma_pkg::dma_cmd_t cmd, input int n);
		dma_pkg::addr_t a;
		dma_pkg::word_t d;
		a = cmd.dst + 32'(n) * 32'd4;
		if (cmd.kind == dma_pkg::CMD_FILL)
			d = cmd.value_or_src;
		else
			d = mem_init(cmd.value_or_src + 32'(n) * 32'd4);
		return {a, d};
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		mismatches++;
		$display("mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
	endtask

	always @(posedge i_clock) begin : compare
		logic [63:0] exp;
		dma_pkg::dma_cmd_t cmd;
		string name;
		if (i_rst) begin
			ready_q <= 1'b0;
			req_q <= 1'b0;
			stall_q <= 1'b0;
			wait_cycles = 0;
		end else begin
			ready_q <= i_cpu_ready;
			req_q <= i_bus_req;
			stall_q <= i_stall;
			if (i_bus_req && !req_q && stall_q) begin
				other_errors++;
				$display("Bus request started although stall was high at %0t", $time);
			end
			if (i_bus_req && !req_q && exp_q.size() == 0) begin
				other_errors++;
				$display("Bus access with no command expecting one at %0t", $time);
			end
			if (i_bus_req && i_bus_rw && i_bus_ready && exp_q.size() > 0) begin
				cmd = exp_q[0];
				exp = expected_write(cmd, word_idx);
				name = (cmd.kind == dma_pkg::CMD_FILL) ? "fill" : "copy";
				if (i_bus_addr !== exp[63:32])
					report_mismatch({name, " addr"}, exp[63:32], i_bus_addr);
				if (i_bus_wdata !== exp[31:0])
					report_mismatch({name, " data"}, exp[31:0], i_bus_wdata);
				word_idx++;
				if (32'(word_idx) == cmd.count) begin
					void'(exp_q.pop_front());
					word_idx = 0;
				end
			end
			if (i_req && !i_cpu_ready)
				wait_cycles++;
			// CPU access completes on the rising edge of ready
			if (i_req && i_cpu_ready && !ready_q) begin
				if (wait_cycles > 1) begin
					if (i_rw && i_addr == dma_pkg::REG_KIND) begin
						cpu_stalls++; // Queue was full
					end else begin
						other_errors++;
						$display("Register access answered after %0d cycles instead of one",
							wait_cycles);
					end
				end
				wait_cycles = 0;
				if (i_rw) begin
					case (i_addr)
						dma_pkg::REG_VALUE: sh_value = i_wdata;
						dma_pkg::REG_DST: sh_dst = i_wdata;
						dma_pkg::REG_COUNT: sh_count = i_wdata;
						default: begin
							cmd = '{kind: dma_pkg::cmd_kind_e'(i_wdata[1:0]),
								value_or_src: sh_value, dst: sh_dst, count: sh_count};
							if (i_wdata[1:0] == 2'd1 || i_wdata[1:0] == 2'd2) begin
								valid_cnt++;
								if (sh_count != 0) exp_q.push_back(cmd);
							end else begin
								invalid_cnt++;
							end
						end
					endcase
				end else begin
					case (i_addr)
						dma_pkg::REG_VALUE: begin
							if (i_rdata !== sh_value)
								report_mismatch("readback value", sh_value, i_rdata);
						end
						dma_pkg::REG_DST: begin
							if (i_rdata !== sh_dst)
								report_mismatch("readback dst", sh_dst, i_rdata);
						end
						dma_pkg::REG_COUNT: begin
							if (i_rdata !== sh_count)
								report_mismatch("readback count", sh_count, i_rdata);
						end
						default: if (i_rdata[0] === 1'b0) begin // Idle, counts are final
							if (i_rdata[31:16] !== 16'(valid_cnt))
								report_mismatch("status done count", 16'(valid_cnt),
									i_rdata[31:16]);
							if (i_rdata[15:8] !== 8'(invalid_cnt))
								report_mismatch("status error count", 8'(invalid_cnt),
									i_rdata[15:8]);
							if (exp_q.size() != 0) begin
								other_errors++;
								$display("Status idle with %0d commands still owing writes",
									exp_q.size());
							end
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_dma_top.sv ====
`default_nettype none

module tb_dma_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int QUEUE_DEPTH = 8;
	localparam int N_BP = 20;     // Well beyond what the queue holds
	localparam int BP_WORDS = 4;
	localparam int TOTAL_WORDS = 6 + 5 + N_BP * BP_WORDS;
	localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + 3000;

	logic i_clock = 1'b0;
	logic i_rst = 1'b1;
	logic i_req;
	logic i_rw;
	dma_pkg::reg_addr_t i_addr;
	dma_pkg::word_t i_wdata;
	dma_pkg::word_t o_rdata;
	logic o_ready;
	logic i_stall = 1'b0;
	logic o_bus_req;
	logic o_bus_rw;
	dma_pkg::addr_t o_bus_addr;
	dma_pkg::word_t o_bus_wdata;
	logic i_bus_ready = 1'b0;
	dma_pkg::word_t i_bus_rdata = '0;
	dma_pkg::word_t mem [dma_pkg::addr_t];
	logic [31:0] lcg_state = 32'd85;
	int wait_cnt = -1;
	logic slow_bus = 1'b0;
	int mismatches;
	int other_errors;
	int pending;
	int cpu_stalls;
	int end_errors;

	dma_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) DUT (.*);

	tb_dma_checker u_checker (
		.i_clock(i_clock), .i_rst(i_rst), .i_req(i_req), .i_rw(i_rw), .i_addr(i_addr),
		.i_wdata(i_wdata), .i_rdata(o_rdata), .i_cpu_ready(o_ready), .i_stall(i_stall),
		.i_bus_req(o_bus_req), .i_bus_rw(o_bus_rw), .i_bus_addr(o_bus_addr),
		.i_bus_wdata(o_bus_wdata), .i_bus_ready(i_bus_ready),
		.o_mismatches(mismatches), .o_other_errors(other_errors), .o_pending(pending),
		.o_cpu_stalls(cpu_stalls)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic dma_pkg::word_t mem_init(input dma_pkg::addr_t a);
		return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
	endfunction

	initial begin
		forever #2 i_clock = ~i_clock;
	end

	// Memory slave with random latency, also drives stall
	always @(posedge i_clock) begin : bus_model
		logic [31:0] r;
		if (i_rst) begin
			i_bus_ready <= 1'b0;
			i_stall <= 1'b0;
			wait_cnt = -1;
		end else begin
			lcg_state = lcg_next(lcg_state);
			r = lcg_state;
			i_stall <= (r[27:25] == 3'd0);
			if (i_bus_ready) begin
				i_bus_ready <= 1'b0;
				wait_cnt = -1;
			end else if (o_bus_req) begin
				if (wait_cnt < 0) wait_cnt = int'(r[17:16]) + (slow_bus ? 4 : 0);
				if (wait_cnt == 0) begin
					i_bus_ready <= 1'b1;
					if (o_bus_rw)
						mem[o_bus_addr] = o_bus_wdata;
					else
						i_bus_rdata <= mem.exists(o_bus_addr) ? mem[o_bus_addr]
							: mem_init(o_bus_addr);
				end else begin
					wait_cnt--;
				end
			end
		end
	end

	task automatic cpu_access(input logic rw, input dma_pkg::reg_addr_t addr,
			input dma_pkg::word_t wdata, output dma_pkg::word_t rdata);
		@(posedge i_clock);
		i_req <= 1'b1;
		i_rw <= rw;
		i_addr <= addr;
		i_wdata <= wdata;
		do @(negedge i_clock); while (!o_ready);
		rdata = o_rdata;
		@(posedge i_clock);
		i_req <= 1'b0;
		@(posedge i_clock); // Ready falls here
	endtask

	task automatic write_reg(input dma_pkg::reg_addr_t addr, input dma_pkg::word_t data);
		dma_pkg::word_t unused;
		cpu_access(1'b1, addr, data, unused);
	endtask

	task automatic issue_cmd(input logic [1:0] kind, input dma_pkg::word_t v,
			input dma_pkg::addr_t dst, input dma_pkg::count_t count);
		write_reg(dma_pkg::REG_VALUE, v);
		write_reg(dma_pkg::REG_DST, dst);
		write_reg(dma_pkg::REG_COUNT, count);
		write_reg(dma_pkg::REG_KIND, {30'd0, kind}); // Stalls while the queue is full
	endtask

	task automatic wait_idle();
		dma_pkg::word_t st;
		do cpu_access(1'b0, dma_pkg::REG_KIND, '0, st); while (st[0]);
	endtask

	task automatic read_fields();
		dma_pkg::word_t d;
		cpu_access(1'b0, dma_pkg::REG_VALUE, '0, d);
		cpu_access(1'b0, dma_pkg::REG_DST, '0, d);
		cpu_access(1'b0, dma_pkg::REG_COUNT, '0, d);
	endtask

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge i_clock);
		$display("Watchdog expired after %0d cycles, DUT did not finish", TIMEOUT_CYCLES);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		i_req = 1'b0;
		i_rw = 1'b0;
		i_addr = '0;
		i_wdata = '0;
		repeat (5) @(posedge i_clock);
		i_rst <= 1'b0;
		write_reg(dma_pkg::REG_VALUE, 32'h1234_5678);
		write_reg(dma_pkg::REG_DST, 32'hCAFE_0000);
		write_reg(dma_pkg::REG_COUNT, 32'd77);
		read_fields();
		issue_cmd(2'd1, 32'hA5A5_0001, 32'h0000_1000, 32'd6);
		issue_cmd(2'd2, 32'h0000_2000, 32'h0000_3000, 32'd5);
		issue_cmd(2'd1, 32'hDEAD_BEEF, 32'h0000_5000, 32'd0);
		issue_cmd(2'd0, 32'h0000_7000, 32'h0000_6000, 32'd4); // Both kinds invalid
		issue_cmd(2'd3, 32'h0000_7000, 32'h0000_6000, 32'd4);
		wait_idle();
		@(posedge i_clock);
		slow_bus <= 1'b1;
		for (int i = 0; i < N_BP; i++) begin
			if (i % 2 == 1)
				issue_cmd(2'd2, 32'h0000_8000 + 32'(i) * 32'h40, 32'h0000_4000 + 32'(i) * 32'h40,
					32'(BP_WORDS));
			else
				issue_cmd(2'd1, 32'h1111_0000 + 32'(i), 32'h0000_4000 + 32'(i) * 32'h40,
					32'(BP_WORDS));
		end
		wait_idle();
		read_fields();
		@(posedge i_clock);
		end_errors = other_errors;
		if (cpu_stalls == 0) begin
			$display("CPU port never stalled on a full queue during the back-pressure phase");
			end_errors++;
		end
		$display("Errors: %0d mismatches, %0d other failures, %0d commands unfinished",
			mismatches, end_errors, pending);
		if (mismatches == 0 && end_errors == 0 && pending == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
dma_pkg.sv
dma_reg_decode.sv
dma_cmd_queue.sv
dma_engine.sv
dma_status.sv
dma_top.sv
tb_dma_checker.sv
tb_dma_top.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile: obj_dir/sim

obj_dir/sim: vlog.f *.sv
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_dma_top -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
